// ==== all.f ====
rtl/turf_ctrl_pkg.sv
rtl/turf_apb_front.sv
rtl/turf_id_bridge.sv
rtl/turf_uart_ticks.sv
rtl/turf_ctrl_top.sv
verif/turf_ctrl_tb.sv

// ==== rtl/turf_apb_front.sv ====
`default_nettype none

module turf_apb_front import turf_ctrl_pkg::*; (
    input  wire                ps_clk,
    input  wire                rst_i,
    input  wire apb_req_t      apb_req_i,
    output apb_rsp_t           apb_rsp_o,
    output reg_req_t           reg_req_o,
    input  wire [DATA_W-1:0]   id_rdata_i,
    input  wire [DATA_W-1:0]   tick_rdata_i
);

    // FSM state
    apb_state_e        state_q;
    // Decoded access strobes
    logic              wr_en_q;
    logic              rd_en_q;
    // Access payload, held through the transfer
    reg_addr_e         addr_q;
    logic [DATA_W-1:0] wdata_q;
    // Error and read source of the current transfer
    logic              err_q;
    logic              tick_sel_q;

    // Bus phase
    logic              setup;
    logic              access;
    // Address decode
    logic              mapped;
    logic              read_only;
    logic              tick_addr;

    ////////////////////////////////////////////////////////////
    // Decode
    ////////////////////////////////////////////////////////////

    always_comb begin
        // Setup has psel only, access has both
        setup  = apb_req_i.psel & ~apb_req_i.penable;
        access = apb_req_i.psel & apb_req_i.penable;
    end

    always_comb begin
        mapped    = 1'b0;
        read_only = 1'b0;
        tick_addr = 1'b0;
        case (apb_req_i.paddr)
            // Constants
            REG_IDENT, REG_DATEVER: begin
                mapped    = 1'b1;
                read_only = 1'b1;
            end
            // Bridge control
            REG_BRIDGE_SEL, REG_BRIDGE_STAT: begin
                mapped = 1'b1;
            end
            // Tick counters live in the other part
            REG_HSK_TICKS, REG_GPS_TICKS: begin
                mapped    = 1'b1;
                tick_addr = 1'b1;
            end
            default: begin
                mapped = 1'b0;
            end
        endcase
    end

    ////////////////////////////////////////////////////////////
    // Transfer FSM
    ////////////////////////////////////////////////////////////

    // Setup seen in IDLE, first access cycle in ACCESS,
    // pready during RESP so one wait state always
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            state_q    <= APB_IDLE;
            wr_en_q    <= 1'b0;
            rd_en_q    <= 1'b0;
            err_q      <= 1'b0;
            tick_sel_q <= 1'b0;
        end else begin
            // Strobes last one cycle
            wr_en_q <= 1'b0;
            rd_en_q <= 1'b0;
            case (state_q)
                APB_IDLE: begin
                    if (setup) begin
                        state_q    <= APB_ACCESS;
                        // Only legal accesses reach the parts
                        wr_en_q    <= apb_req_i.pwrite & mapped & ~read_only;
                        rd_en_q    <= ~apb_req_i.pwrite & mapped;
                        err_q      <= ~mapped | (apb_req_i.pwrite & read_only);
                        tick_sel_q <= tick_addr;
                    end
                end
                APB_ACCESS: begin
                    // Master dropped psel, abandon
                    if (access) begin
                        state_q <= APB_RESP;
                    end else begin
                        state_q <= APB_IDLE;
                    end
                end
                APB_RESP: begin
                    state_q <= APB_IDLE;
                end
                default: begin
                    state_q <= APB_IDLE;
                end
            endcase
        end
    end

    // Latch address and write data at setup
    always_ff @(posedge ps_clk) begin
        if (state_q == APB_IDLE && setup) begin
            addr_q  <= reg_addr_e'(apb_req_i.paddr);
            wdata_q <= apb_req_i.pwdata;
        end
    end

    ////////////////////////////////////////////////////////////
    // Outputs
    ////////////////////////////////////////////////////////////

    always_comb begin
        reg_req_o.wr_en = wr_en_q;
        reg_req_o.rd_en = rd_en_q;
        reg_req_o.addr  = addr_q;
        reg_req_o.wdata = wdata_q;
    end

    always_comb begin
        apb_rsp_o.pready  = (state_q == APB_RESP);
        apb_rsp_o.pslverr = (state_q == APB_RESP) & err_q;
        // Parts hold their word from the edge entering RESP
        apb_rsp_o.prdata  = tick_sel_q ? tick_rdata_i : id_rdata_i;
    end

endmodule

`default_nettype wire

// ==== rtl/turf_ctrl_pkg.sv ====
`default_nettype none

package turf_ctrl_pkg;

    ////////////////////////////////////////////////////////////
    // Widths
    ////////////////////////////////////////////////////////////

    // APB byte address
    localparam int APB_ADDR_W = 12;
    // Register data
    localparam int DATA_W = 32;
    // Crate links
    localparam int NUM_LINKS = 4;
    // One bridge type field per link
    localparam int BRIDGE_W = 2;
    // Phase accumulators of the 16x generators
    localparam int HSK_ACC_W = 10;
    localparam int GPS_ACC_W = 12;
    // Readable tick counters
    localparam int TICK_CNT_W = 16;

    ////////////////////////////////////////////////////////////
    // APB bus
    ////////////////////////////////////////////////////////////

    // Request from the master
    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [DATA_W-1:0]     pwdata;
    } apb_req_t;

    // Response back to the master
    typedef struct packed {
        logic [DATA_W-1:0] prdata;
        logic              pready;
        logic              pslverr;
    } apb_rsp_t;

    // Front end FSM
    typedef enum logic [1:0] {
        APB_IDLE,
        APB_ACCESS,
        APB_RESP
    } apb_state_e;

    ////////////////////////////////////////////////////////////
    // Register map
    ////////////////////////////////////////////////////////////

    // Byte addresses, anything else is unmapped
    typedef enum logic [APB_ADDR_W-1:0] {
        REG_IDENT       = 12'h000,
        REG_DATEVER     = 12'h004,
        REG_BRIDGE_SEL  = 12'h008,
        REG_BRIDGE_STAT = 12'h00C,
        REG_HSK_TICKS   = 12'h010,
        REG_GPS_TICKS   = 12'h014
    } reg_addr_e;

    // Decoded access, one cycle wide
    typedef struct packed {
        logic              wr_en;
        logic              rd_en;
        reg_addr_e         addr;
        logic [DATA_W-1:0] wdata;
    } reg_req_t;

    // Register bridge type per crate link
    typedef enum logic [BRIDGE_W-1:0] {
        BRIDGE_NONE   = 2'd0,
        BRIDGE_AURORA = 2'd1,
        BRIDGE_RSVD2  = 2'd2,
        BRIDGE_RSVD3  = 2'd3
    } bridge_type_e;

endpackage

`default_nettype wire

// ==== rtl/turf_ctrl_top.sv ====
`default_nettype none

module turf_ctrl_top import turf_ctrl_pkg::*; #(
    parameter logic [DATA_W-1:0]    IDENT       = "TURF",
    // Rev flag, 15-bit date, version 0.2.26
    parameter logic [DATA_W-1:0]    DATEVERSION = 32'h0000_021A,
    parameter logic [HSK_ACC_W-1:0] HSK_ADD     = 10'd82,
    parameter logic [GPS_ACC_W-1:0] GPS_ADD     = 12'd25
) (
    input  wire                          ps_clk,
    input  wire                          rst_i,
    input  wire apb_req_t                apb_req_i,
    output apb_rsp_t                     apb_rsp_o,
    input  wire [NUM_LINKS-1:0]          link_up_i,
    output bridge_type_e [NUM_LINKS-1:0] bridge_type_o,
    output logic                         hsk_tick_o,
    output logic                         gps_tick_o
);

    // Decoded access to both parts
    reg_req_t          reg_req;
    // Read words back from each part
    logic [DATA_W-1:0] id_rdata;
    logic [DATA_W-1:0] tick_rdata;

    ////////////////////////////////////////////////////////////
    // APB front end
    ////////////////////////////////////////////////////////////

    turf_apb_front u_front (
        .ps_clk       (ps_clk),
        .rst_i        (rst_i),
        .apb_req_i    (apb_req_i),
        .apb_rsp_o    (apb_rsp_o),
        .reg_req_o    (reg_req),
        .id_rdata_i   (id_rdata),
        .tick_rdata_i (tick_rdata)
    );

    ////////////////////////////////////////////////////////////
    // Register parts
    ////////////////////////////////////////////////////////////

    // Identity and crate bridge control
    turf_id_bridge #(
        .IDENT       (IDENT),
        .DATEVERSION (DATEVERSION)
    ) u_id_bridge (
        .ps_clk        (ps_clk),
        .rst_i         (rst_i),
        .reg_req_i     (reg_req),
        .rdata_o       (id_rdata),
        .link_up_i     (link_up_i),
        .bridge_type_o (bridge_type_o)
    );

    // UART 16x ticks
    turf_uart_ticks #(
        .HSK_ADD (HSK_ADD),
        .GPS_ADD (GPS_ADD)
    ) u_ticks (
        .ps_clk     (ps_clk),
        .rst_i      (rst_i),
        .reg_req_i  (reg_req),
        .rdata_o    (tick_rdata),
        .hsk_tick_o (hsk_tick_o),
        .gps_tick_o (gps_tick_o)
    );

endmodule

`default_nettype wire

// ==== rtl/turf_id_bridge.sv ====
`default_nettype none

module turf_id_bridge import turf_ctrl_pkg::*; #(
    parameter logic [DATA_W-1:0] IDENT       = "TURF",
    parameter logic [DATA_W-1:0] DATEVERSION = 32'h0000_021A
) (
    input  wire                          ps_clk,
    input  wire                          rst_i,
    input  wire reg_req_t                reg_req_i,
    output logic [DATA_W-1:0]            rdata_o,
    input  wire [NUM_LINKS-1:0]          link_up_i,
    output bridge_type_e [NUM_LINKS-1:0] bridge_type_o
);

    // Sticky flags, one per link
    logic [NUM_LINKS-1:0]         invalid_q;
    // Write data split into per-link types
    bridge_type_e [NUM_LINKS-1:0] wr_type;
    // New type usable on that link right now
    logic [NUM_LINKS-1:0]         wr_ok;
    // Register hits
    logic                         sel_wr;
    logic                         stat_wr;

    ////////////////////////////////////////////////////////////
    // Validity rule
    ////////////////////////////////////////////////////////////

    // NONE always ok, Aurora needs the link up
    // Reserved codes never ok
    function automatic logic type_valid(input bridge_type_e t, input logic up);
        case (t)
            BRIDGE_NONE: begin
                return 1'b1;
            end
            BRIDGE_AURORA: begin
                return up;
            end
            default: begin
                return 1'b0;
            end
        endcase
    endfunction

    always_comb begin
        sel_wr  = reg_req_i.wr_en & (reg_req_i.addr == REG_BRIDGE_SEL);
        stat_wr = reg_req_i.wr_en & (reg_req_i.addr == REG_BRIDGE_STAT);
    end

    // Link n sits at bits 2n+1:2n
    always_comb begin
        for (int n = 0; n < NUM_LINKS; n++) begin
            wr_type[n] = bridge_type_e'(reg_req_i.wdata[BRIDGE_W*n +: BRIDGE_W]);
            wr_ok[n]   = type_valid(wr_type[n], link_up_i[n]);
        end
    end

    ////////////////////////////////////////////////////////////
    // Selection and status
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            // All links start unbridged
            for (int n = 0; n < NUM_LINKS; n++) begin
                bridge_type_o[n] <= BRIDGE_NONE;
            end
            invalid_q <= '0;
        end else if (sel_wr) begin
            // Selection always taken, bad ones flagged
            bridge_type_o <= wr_type;
            invalid_q     <= invalid_q | ~wr_ok;
        end else if (stat_wr) begin
            // Write 1 to clear
            invalid_q <= invalid_q & ~reg_req_i.wdata[NUM_LINKS-1:0];
        end
    end

    ////////////////////////////////////////////////////////////
    // Read back
    ////////////////////////////////////////////////////////////

    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (reg_req_i.rd_en) begin
            case (reg_req_i.addr)
                REG_IDENT: begin
                    rdata_o <= IDENT;
                end
                // Rev flag, date, then major/minor/rev
                REG_DATEVER: begin
                    rdata_o <= DATEVERSION;
                end
                REG_BRIDGE_SEL: begin
                    rdata_o <= DATA_W'(bridge_type_o);
                end
                // Link status above the flags
                REG_BRIDGE_STAT: begin
                    rdata_o <= DATA_W'({link_up_i, invalid_q});
                end
                // Tick registers belong elsewhere
                default: begin
                    rdata_o <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== rtl/turf_uart_ticks.sv ====
`default_nettype none

module turf_uart_ticks import turf_ctrl_pkg::*; #(
    parameter logic [HSK_ACC_W-1:0] HSK_ADD = 10'd82,
    parameter logic [GPS_ACC_W-1:0] GPS_ADD = 12'd25
) (
    input  wire               ps_clk,
    input  wire               rst_i,
    input  wire reg_req_t     reg_req_i,
    output logic [DATA_W-1:0] rdata_o,
    output logic              hsk_tick_o,
    output logic              gps_tick_o
);

    // Generator 0 is housekeeping, 1 is GPS
    localparam int NUM_GEN = 2;

    wire  [NUM_GEN-1:0]                 tick;
    wire  [NUM_GEN-1:0][TICK_CNT_W-1:0] tick_cnt;
    // Counter clear on write
    logic [NUM_GEN-1:0]                 cnt_clr;

    always_comb begin
        cnt_clr[0] = reg_req_i.wr_en & (reg_req_i.addr == REG_HSK_TICKS);
        cnt_clr[1] = reg_req_i.wr_en & (reg_req_i.addr == REG_GPS_TICKS);
    end

    ////////////////////////////////////////////////////////////
    // Fractional 16x generators
    ////////////////////////////////////////////////////////////

    // 82/1024 of 100 MHz is about 8 MHz
    // 25/4096 of 100 MHz is about 16 x 38400
    for (genvar g = 0; g < NUM_GEN; g++) begin : g_gen
        localparam int ACC_W = (g == 0) ? HSK_ACC_W : GPS_ACC_W;
        localparam logic [ACC_W-1:0] ADD = (g == 0) ? ACC_W'(HSK_ADD) : ACC_W'(GPS_ADD);

        logic [ACC_W-1:0]      acc_q;
        logic                  carry_q;
        logic [TICK_CNT_W-1:0] cnt_q;

        // Carry out of the phase wrap is the tick
        always_ff @(posedge ps_clk) begin
            if (rst_i) begin
                acc_q   <= '0;
                carry_q <= 1'b0;
            end else begin
                {carry_q, acc_q} <= {1'b0, acc_q} + {1'b0, ADD};
            end
        end

        // Clear beats a coincident tick
        always_ff @(posedge ps_clk) begin
            if (rst_i || cnt_clr[g]) begin
                cnt_q <= '0;
            end else if (carry_q) begin
                cnt_q <= cnt_q + 1'b1;
            end
        end

        assign tick[g]     = carry_q;
        assign tick_cnt[g] = cnt_q;
    end

    always_comb begin
        hsk_tick_o = tick[0];
        gps_tick_o = tick[1];
    end

    // Counters in the low half
    always_ff @(posedge ps_clk) begin
        if (rst_i) begin
            rdata_o <= '0;
        end else if (reg_req_i.rd_en) begin
            case (reg_req_i.addr)
                REG_HSK_TICKS: begin
                    rdata_o <= DATA_W'(tick_cnt[0]);
                end
                REG_GPS_TICKS: begin
                    rdata_o <= DATA_W'(tick_cnt[1]);
                end
                default: begin
                    rdata_o <= '0;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the TURF control testbench with Verilator
set -u
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --timescale 1ns/1ps \
    -f all.f --top-module turf_ctrl_tb -Mdir obj_dir -o turf_ctrl_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/turf_ctrl_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Test completed successfully$" "$LOG"; then
    exit 0
fi
exit 1

// ==== verif/turf_ctrl_tb.sv ====
`default_nettype none

module turf_ctrl_tb import turf_ctrl_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    // "TUR1" in ASCII
    localparam logic [DATA_W-1:0] IDENT_VAL   = 32'h5455_5231;
    localparam logic [DATA_W-1:0] DATEVER_VAL = 32'h8B5A_0312;
    localparam int HSK_ADD_VAL    = 83;
    localparam int GPS_ADD_VAL    = 26;
    localparam int TIMEOUT_CYCLES = 20;
    localparam int NUM_RAND       = 12;

    logic                         ps_clk;
    logic                         rst_i;
    apb_req_t                     apb_req;
    apb_rsp_t                     apb_rsp;
    logic [NUM_LINKS-1:0]         link_up;
    bridge_type_e [NUM_LINKS-1:0] bridge_type;
    logic [2*NUM_LINKS-1:0]       bridge_bits;
    logic                         hsk_tick;
    logic                         gps_tick;

    integer seed = 32'h55f7_175f;
    int     errors;
    int     tests_run;
    int     tests_failed;
    int     test_start_errors;
    // Running tick totals seen at the ports
    int     hsk_total;
    int     gps_total;

    turf_ctrl_top #(
        .IDENT       (IDENT_VAL),
        .DATEVERSION (DATEVER_VAL),
        .HSK_ADD     (10'(HSK_ADD_VAL)),
        .GPS_ADD     (12'(GPS_ADD_VAL))
    ) i_dut (
        .ps_clk        (ps_clk),
        .rst_i         (rst_i),
        .apb_req_i     (apb_req),
        .apb_rsp_o     (apb_rsp),
        .link_up_i     (link_up),
        .bridge_type_o (bridge_type),
        .hsk_tick_o    (hsk_tick),
        .gps_tick_o    (gps_tick)
    );

    assign bridge_bits = bridge_type;

    initial ps_clk = 1'b0;
    always #2 ps_clk = ~ps_clk;

    always @(posedge ps_clk) begin
        if (rst_i) begin
            hsk_total <= 0;
            gps_total <= 0;
        end else begin
            if (hsk_tick) hsk_total <= hsk_total + 1;
            if (gps_tick) gps_total <= gps_total + 1;
        end
    end

    ////////////////////////////////////////////////////////////
    // APB protocol
    ////////////////////////////////////////////////////////////

    // One wait state puts pready two edges after setup
    assert property (@(posedge ps_clk) disable iff (rst_i)
        (apb_req.psel && !apb_req.penable) |-> ##2 apb_rsp.pready)
    else begin
        $display("Protocol error at %0t: pready missing two cycles after setup", $time);
        errors++;
    end

    // Never early
    assert property (@(posedge ps_clk) disable iff (rst_i)
        (apb_req.psel && !apb_req.penable) |-> ##1 !apb_rsp.pready)
    else begin
        $display("Protocol error at %0t: pready came without a wait state", $time);
        errors++;
    end

    assert property (@(posedge ps_clk) disable iff (rst_i) apb_rsp.pready |-> apb_req.psel)
    else begin
        $display("Protocol error at %0t: pready while psel was low", $time);
        errors++;
    end

    assert property (@(posedge ps_clk) disable iff (rst_i) apb_rsp.pslverr |-> apb_rsp.pready)
    else begin
        $display("Protocol error at %0t: pslverr outside the pready cycle", $time);
        errors++;
    end

    ////////////////////////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////////////////////////

    task automatic check_value(input string name, input logic [DATA_W-1:0] actual,
                               input logic [DATA_W-1:0] expected);
        assert (actual === expected)
        else begin
            $display("ERROR %0t: %s expected 0x%08h, got 0x%08h", $time, name, expected, actual);
            errors++;
        end
    endtask

    // Setup, access, then wait for pready
    task automatic apb_transfer(input logic write, input logic [APB_ADDR_W-1:0] addr,
                                input logic [DATA_W-1:0] wdata,
                                output logic [DATA_W-1:0] rdata, output logic slverr);
        int waited;
        @(posedge ps_clk);
        apb_req.psel    <= 1'b1;
        apb_req.penable <= 1'b0;
        apb_req.pwrite  <= write;
        apb_req.paddr   <= addr;
        apb_req.pwdata  <= wdata;
        @(posedge ps_clk);
        apb_req.penable <= 1'b1;
        waited = 0;
        do begin
            @(posedge ps_clk);
            waited++;
        end while (!apb_rsp.pready && waited < TIMEOUT_CYCLES);
        if (!apb_rsp.pready) begin
            $display("APB transfer to 0x%03h got no pready within %0d cycles",
                     addr, TIMEOUT_CYCLES);
            $display("Test failed");
            $finish;
        end else begin
            rdata = apb_rsp.prdata;
            slverr = apb_rsp.pslverr;
            apb_req.psel    <= 1'b0;
            apb_req.penable <= 1'b0;
        end
    endtask

    task automatic write_reg(input logic [APB_ADDR_W-1:0] addr, input logic [DATA_W-1:0] wdata,
                             input logic exp_err);
        logic [DATA_W-1:0] rdata;
        logic              slverr;
        apb_transfer(1'b1, addr, wdata, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'(exp_err));
    endtask

    task automatic read_reg(input logic [APB_ADDR_W-1:0] addr, output logic [DATA_W-1:0] rdata,
                            input logic exp_err);
        logic slverr;
        apb_transfer(1'b0, addr, '0, rdata, slverr);
        check_value("pslverr", 32'(slverr), 32'(exp_err));
    endtask

    task automatic expect_read(input logic [APB_ADDR_W-1:0] addr, input string name,
                               input logic [DATA_W-1:0] expected);
        logic [DATA_W-1:0] rdata;
        read_reg(addr, rdata, 1'b0);
        check_value(name, rdata, expected);
    endtask

    // Code 0 always usable
    // Code 1 needs its link up
    // Codes 2 and 3 never usable
    function automatic logic [NUM_LINKS-1:0] invalid_mask(input logic [2*NUM_LINKS-1:0] sel,
                                                          input logic [NUM_LINKS-1:0] up);
        logic [NUM_LINKS-1:0] bad;
        logic [1:0]           code;
        bad = '0;
        for (int n = 0; n < NUM_LINKS; n++) begin
            code = sel[2*n +: 2];
            bad[n] = !((code == 2'd0) || (code == 2'd1 && up[n]));
        end
        return bad;
    endfunction

    task automatic start_test();
        test_start_errors = errors;
    endtask

    task automatic finish_test(input string name);
        tests_run++;
        if (errors == test_start_errors) begin
            $display("%-28s ok", name);
        end else begin
            tests_failed++;
            $display("%-28s %0d error(s)", name, errors - test_start_errors);
        end
    endtask

    ////////////////////////////////////////////////////////////
    // Tests
    ////////////////////////////////////////////////////////////

    task automatic identity_after_reset();
        start_test();
        check_value("bridge_type_o", 32'(bridge_bits), 32'h0);
        expect_read(REG_IDENT, "REG_IDENT", IDENT_VAL);
        expect_read(REG_DATEVER, "REG_DATEVER", DATEVER_VAL);
        finish_test("identity after reset");
    endtask

    task automatic random_bridge_select();
        logic [31:0]            rnd;
        logic [NUM_LINKS-1:0]   up;
        logic [2*NUM_LINKS-1:0] sel;
        start_test();
        for (int i = 0; i < NUM_RAND; i++) begin
            rnd = $random(seed);
            up  = rnd[NUM_LINKS-1:0];
            rnd = $random(seed);
            sel = rnd[2*NUM_LINKS-1:0];
            @(posedge ps_clk);
            link_up <= up;
            // Start each round with clean flags
            write_reg(REG_BRIDGE_STAT, 32'hF, 1'b0);
            write_reg(REG_BRIDGE_SEL, 32'(sel), 1'b0);
            check_value("bridge_type_o", 32'(bridge_bits), 32'(sel));
            expect_read(REG_BRIDGE_SEL, "REG_BRIDGE_SEL", 32'(sel));
            expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'({up, invalid_mask(sel, up)}));
        end
        finish_test("random bridge select");
    endtask

    task automatic sticky_invalid_bits();
        logic [NUM_LINKS-1:0] exp_invalid;
        start_test();
        @(posedge ps_clk);
        link_up <= 4'b0101;
        write_reg(REG_BRIDGE_STAT, 32'hF, 1'b0);
        // All reserved so every link gets flagged
        write_reg(REG_BRIDGE_SEL, 32'hAA, 1'b0);
        exp_invalid = invalid_mask(8'hAA, 4'b0101);
        expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'({4'b0101, exp_invalid}));
        // Valid selection keeps the flags
        write_reg(REG_BRIDGE_SEL, 32'h11, 1'b0);
        exp_invalid = exp_invalid | invalid_mask(8'h11, 4'b0101);
        expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'({4'b0101, exp_invalid}));
        // Write ones to clear half the flags at a time
        write_reg(REG_BRIDGE_STAT, 32'h5, 1'b0);
        exp_invalid = exp_invalid & ~4'h5;
        expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'({4'b0101, exp_invalid}));
        write_reg(REG_BRIDGE_STAT, 32'hA, 1'b0);
        exp_invalid = exp_invalid & ~4'hA;
        expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'({4'b0101, exp_invalid}));
        finish_test("sticky invalid bits");
    endtask

    task automatic illegal_accesses();
        logic [DATA_W-1:0] rdata;
        start_test();
        @(posedge ps_clk);
        link_up <= 4'b0000;
        write_reg(REG_BRIDGE_STAT, 32'hF, 1'b0);
        // Aurora on two down links sets flags 0011
        write_reg(REG_BRIDGE_SEL, 32'h05, 1'b0);
        read_reg(12'h020, rdata, 1'b1);
        write_reg(12'h009, 32'hFF, 1'b1);
        write_reg(12'h00D, 32'hF, 1'b1);
        write_reg(12'h018, 32'hFFFF_FFFF, 1'b1);
        write_reg(REG_IDENT, 32'h0, 1'b1);
        write_reg(REG_DATEVER, ~DATEVER_VAL, 1'b1);
        // Nothing moved
        check_value("bridge_type_o", 32'(bridge_bits), 32'h05);
        expect_read(REG_IDENT, "REG_IDENT", IDENT_VAL);
        expect_read(REG_DATEVER, "REG_DATEVER", DATEVER_VAL);
        expect_read(REG_BRIDGE_SEL, "REG_BRIDGE_SEL", 32'h05);
        expect_read(REG_BRIDGE_STAT, "REG_BRIDGE_STAT", 32'h03);
        finish_test("illegal accesses");
    endtask

    // One accumulator period holds exactly ADD carries
    task automatic tick_rates();
        int hsk_cnt;
        int gps_cnt;
        start_test();
        hsk_cnt = 0;
        gps_cnt = 0;
        for (int c = 0; c < 4096; c++) begin
            @(posedge ps_clk);
            if (hsk_tick) hsk_cnt++;
            if (gps_tick) gps_cnt++;
            if (c % 1024 == 1023) begin
                check_value("hsk_tick_o per 1024 cycles", hsk_cnt, HSK_ADD_VAL);
                hsk_cnt = 0;
            end
        end
        check_value("gps_tick_o per 4096 cycles", gps_cnt, GPS_ADD_VAL);
        finish_test("tick rates");
    endtask

    task automatic tick_counter_clear(input logic [APB_ADDR_W-1:0] addr, input logic is_gps,
                                      input int idle, input string name);
        logic [DATA_W-1:0] rdata;
        int                start_cnt;
        int                port_cnt;
        int                diff;
        start_test();
        write_reg(addr, 32'h0, 1'b0);
        start_cnt = is_gps ? gps_total : hsk_total;
        repeat (idle) @(posedge ps_clk);
        read_reg(addr, rdata, 1'b0);
        port_cnt = (is_gps ? gps_total : hsk_total) - start_cnt;
        check_value({name, " upper bits"}, 32'(rdata[31:16]), 32'h0);
        diff = port_cnt - int'(rdata[15:0]);
        assert (diff >= -1 && diff <= 1)
        else begin
            $display("ERROR %0t: %s expected %0d (+/-1), got %0d", $time, name,
                     port_cnt, rdata[15:0]);
            errors++;
        end
        finish_test({name, " clear"});
    endtask

    ////////////////////////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////////////////////////

    initial begin
        rst_i        = 1'b1;
        apb_req      = '0;
        link_up      = '0;
        errors       = 0;
        tests_run    = 0;
        tests_failed = 0;
        repeat (3) @(posedge ps_clk);
        rst_i <= 1'b0;

        identity_after_reset();
        random_bridge_select();
        sticky_invalid_bits();
        illegal_accesses();
        tick_rates();
        tick_counter_clear(REG_HSK_TICKS, 1'b0, 300, "REG_HSK_TICKS");
        tick_counter_clear(REG_GPS_TICKS, 1'b1, 1000, "REG_GPS_TICKS");

        $display("%0d tests run, %0d failed, %0d errors", tests_run, tests_failed, errors);
        if (errors == 0) begin
            $display("Test completed successfully");
        end else begin
            $display("Test failed");
        end
        $finish;
    end

endmodule

`default_nettype wire
